// File: Bender.yml
package:
  name: wb_stage

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/wb_pkg.sv
      - source/csr_decode.sv
      - source/csr_file.sv
      - source/wb_result.sv
      - source/wb_stage.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/wb_tb.sv

// File: source/csr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module csr_decode
	import wb_pkg::*;
(
	input	mem_wb_t		item,
	output	csr_sel_t		csr_sel
);

	csr_idx_e	idx;
	logic		mapped;

	//////////////////////////////
	// Address map
	always_comb begin
		case (item.csr_addr)
			`WB_CSR_FFLAGS:		idx = CSR_IDX_FFLAGS;
			`WB_CSR_FRM:		idx = CSR_IDX_FRM;
			`WB_CSR_FCSR:		idx = CSR_IDX_FCSR;
			`WB_CSR_MSTATUS:	idx = CSR_IDX_MSTATUS;
			`WB_CSR_MISA:		idx = CSR_IDX_MISA;
			`WB_CSR_MIE:		idx = CSR_IDX_MIE;
			`WB_CSR_MTVEC:		idx = CSR_IDX_MTVEC;
			`WB_CSR_MSCRATCH:	idx = CSR_IDX_MSCRATCH;
			`WB_CSR_MEPC:		idx = CSR_IDX_MEPC;
			`WB_CSR_MCAUSE:		idx = CSR_IDX_MCAUSE;
			`WB_CSR_MIP:		idx = CSR_IDX_MIP;
			default:			idx = CSR_UNMAPPED;
		endcase
	end

	assign mapped = (idx != CSR_UNMAPPED);

	//////////////////////////////
	// Access rights
	always_comb begin
		csr_sel.idx		= idx;
		csr_sel.op		= item.csr_op;
		csr_sel.rd_ok	= mapped && item.csr_rena;
		csr_sel.wr_ok	= mapped && (idx != CSR_IDX_MIP);	// mip follows the lines only
	end

endmodule

`default_nettype wire

// File: source/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module csr_file
	import wb_pkg::*;
(
	input	logic							clk,
	input	logic							reset,
	input	logic							accept,
	input	mem_wb_t						item,
	input	csr_sel_t						csr_sel,
	input	logic	[`WB_NUM_IRQ_EXT-1:0]	irq_ext,
	input	logic							irq_int_controller,
	input	logic							irq_timer,
	input	logic							irq_software,
	output	logic	[`WB_XLEN-1:0]			csr_rdata,
	output	csr_status_t					status
);

	logic					mstatus_mie;
	logic					mstatus_mpie;
	logic	[1:0]			mstatus_fs;
	logic	[`WB_XLEN-1:0]	misa, mie, mtvec, mscratch, mepc, mcause;
	logic	[4:0]			fflags;
	logic	[2:0]			frm;

	logic	[`WB_XLEN-1:0]	mstatus, mip, old_value, new_value;
	logic	[4:0]			fflags_wr;
	logic	[4:0]			irq_code;
	logic					csr_we, int_take, exc_take;

	assign mstatus = {mstatus_fs == 2'b11, 16'b0, mstatus_fs, 2'b11, 3'b0,
		mstatus_mpie, 3'b0, mstatus_mie, 3'b0};	// MPP fixed to machine
	assign mip = {irq_ext, 4'b0, irq_int_controller, 3'b0, irq_timer, 3'b0,
		irq_software, 3'b0};

	//////////////////////////////
	// Read and op result
	always_comb begin
		case (csr_sel.idx)
			CSR_IDX_FFLAGS:		old_value = {27'b0, fflags};
			CSR_IDX_FRM:		old_value = {29'b0, frm};
			CSR_IDX_FCSR:		old_value = {24'b0, frm, fflags};
			CSR_IDX_MSTATUS:	old_value = mstatus;
			CSR_IDX_MISA:		old_value = misa;
			CSR_IDX_MIE:		old_value = mie;
			CSR_IDX_MTVEC:		old_value = mtvec;
			CSR_IDX_MSCRATCH:	old_value = mscratch;
			CSR_IDX_MEPC:		old_value = mepc;
			CSR_IDX_MCAUSE:		old_value = mcause;
			CSR_IDX_MIP:		old_value = mip;
			default:			old_value = '0;
		endcase

		case (csr_sel.op)
			CSR_RW:		new_value = item.csr_wdata;
			CSR_RS:		new_value = old_value | item.csr_wdata;
			CSR_RC:		new_value = old_value & ~item.csr_wdata;
			default:	new_value = old_value;
		endcase
	end

	assign csr_rdata	= csr_sel.rd_ok ? old_value : '0;
	assign csr_we		= accept && item.csr_wena && csr_sel.wr_ok && !item.exc_pend;
	assign fflags_wr	= (csr_we && (csr_sel.idx == CSR_IDX_FFLAGS ||
		csr_sel.idx == CSR_IDX_FCSR)) ? new_value[4:0] : fflags;

	//////////////////////////////
	// Interrupt priority
	always_comb begin
		irq_code = '0;
		for (int i = `WB_NUM_IRQ_EXT-1; i >= 0; i--) begin	// Lowest index wins
			if (irq_ext[i] && mie[16+i])
				irq_code = 5'(16 + i);
		end
		if (irq_timer && mie[7])
			irq_code = 5'd7;
		if (irq_software && mie[3])
			irq_code = 5'd3;
		if (irq_int_controller && mie[11])
			irq_code = 5'd11;
	end

	assign exc_take	= accept && item.exc_pend;
	assign int_take	= accept && !item.exc_pend && mstatus_mie && |(mip & mie);

	always_comb begin
		status.m_ena		= misa[12];
		status.f_ena		= misa[5] && (mstatus_fs != 2'b00);
		status.fpu_rm		= frm;
		status.int_taken	= int_take;
		status.exc_taken	= exc_take;
		status.trap_taken	= int_take || exc_take;
		status.trap_addr	= {mtvec[`WB_XLEN-1:2], 2'b00};	// Direct mode only
		status.trap_raddr	= mepc;
	end

	//////////////////////////////
	// State update
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			mstatus_mie		<= 1'b0;
			mstatus_mpie	<= 1'b0;
			mstatus_fs		<= 2'b01;	// Initial
			misa			<= `WB_MISA_RESET;
			mie				<= '0;
			mtvec			<= `WB_MTVEC_RESET;
			mscratch		<= '0;
			mepc			<= '0;
			mcause			<= '0;
			fflags			<= '0;
			frm				<= '0;
		end else if (accept) begin
			if (csr_we) begin
				case (csr_sel.idx)
					CSR_IDX_FRM:		frm <= new_value[2:0];
					CSR_IDX_FCSR:		frm <= new_value[7:5];
					CSR_IDX_MSTATUS: begin
						mstatus_mie		<= new_value[3];
						mstatus_mpie	<= new_value[7];
						mstatus_fs		<= new_value[14:13];
					end
					CSR_IDX_MISA:		misa <= new_value;
					CSR_IDX_MIE:		mie <= new_value;
					CSR_IDX_MTVEC:		mtvec <= new_value;
					CSR_IDX_MSCRATCH:	mscratch <= new_value;
					CSR_IDX_MEPC:		mepc <= new_value;
					CSR_IDX_MCAUSE:		mcause <= new_value;
					default: ;
				endcase
			end

			fflags <= fflags_wr | item.fpu_flags;	// Sticky

			if (item.rd_wena && item.rd_addr[5])
				mstatus_fs <= 2'b11;

			if (item.exc_pend) begin
				mepc			<= item.pc;
				mcause			<= item.exc_cause;
				mstatus_mpie	<= mstatus_mie;
				mstatus_mie		<= 1'b0;
			end else if (int_take) begin
				mepc			<= item.pc + 32'd4;	// Item itself retires
				mcause			<= {1'b1, {(`WB_XLEN-6){1'b0}}, irq_code};
				mstatus_mpie	<= mstatus_mie;
				mstatus_mie		<= 1'b0;
			end else if (item.trap_ret) begin
				mstatus_mie		<= mstatus_mpie;
				mstatus_mpie	<= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

//////////////////////////////
// Widths
`define WB_XLEN				32
`define WB_NUM_IRQ_EXT		16

//////////////////////////////
// Reset values
`define WB_MTVEC_RESET		32'h0000_0100
`define WB_MISA_RESET		32'h4000_1120	// RV32 with I, M and F

//////////////////////////////
// CSR addresses
`define WB_CSR_FFLAGS		12'h001
`define WB_CSR_FRM			12'h002
`define WB_CSR_FCSR			12'h003
`define WB_CSR_MSTATUS		12'h300
`define WB_CSR_MISA			12'h301
`define WB_CSR_MIE			12'h304
`define WB_CSR_MTVEC		12'h305
`define WB_CSR_MSCRATCH		12'h340
`define WB_CSR_MEPC			12'h341
`define WB_CSR_MCAUSE		12'h342
`define WB_CSR_MIP			12'h344

`endif

// File: source/wb_pkg.sv
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS,
		CSR_RC
	} csr_op_e;

	typedef enum logic [2:0] {
		SEL_ALU,
		SEL_MEM,
		SEL_FPU,
		SEL_CSR
	} wb_src_e;

	typedef enum logic [3:0] {
		CSR_IDX_FFLAGS,
		CSR_IDX_FRM,
		CSR_IDX_FCSR,
		CSR_IDX_MSTATUS,
		CSR_IDX_MISA,
		CSR_IDX_MIE,
		CSR_IDX_MTVEC,
		CSR_IDX_MSCRATCH,
		CSR_IDX_MEPC,
		CSR_IDX_MCAUSE,
		CSR_IDX_MIP,
		CSR_UNMAPPED
	} csr_idx_e;

	//////////////////////////////
	// Item retiring from the memory stage
	typedef struct packed {
		logic	[`WB_XLEN-1:0]	pc;
		logic	[`WB_XLEN-1:0]	ir;
		logic					rd_wena;
		logic	[5:0]			rd_addr;	// Bit 5 selects FPU regs
		logic	[`WB_XLEN-1:0]	rd_data;
		logic	[11:0]			csr_addr;
		logic					csr_rena;
		logic					csr_wena;
		logic	[`WB_XLEN-1:0]	csr_wdata;
		wb_src_e				wb_src;
		csr_op_e				csr_op;
		logic	[4:0]			fpu_flags;
		logic					trap_ret;
		logic					exc_pend;
		logic	[`WB_XLEN-1:0]	exc_cause;
	} mem_wb_t;

	typedef struct packed {
		csr_idx_e				idx;
		csr_op_e				op;
		logic					rd_ok;
		logic					wr_ok;
	} csr_sel_t;

	typedef struct packed {
		logic					wena;
		logic	[5:0]			addr;
		logic	[`WB_XLEN-1:0]	data;
	} rf_write_t;

	typedef struct packed {
		logic	[`WB_XLEN-1:0]	pc;
		logic	[`WB_XLEN-1:0]	ir;
	} wb_retire_t;

	typedef struct packed {
		logic					m_ena;
		logic					f_ena;
		logic	[2:0]			fpu_rm;
		logic					int_taken;
		logic					exc_taken;
		logic					trap_taken;
		logic	[`WB_XLEN-1:0]	trap_addr;
		logic	[`WB_XLEN-1:0]	trap_raddr;
	} csr_status_t;

endpackage

`default_nettype wire

// File: source/wb_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_result
	import wb_pkg::*;
(
	input	logic					clk,
	input	logic					reset,
	input	logic					accept,
	input	logic					ready_in,
	input	mem_wb_t				item,
	input	logic	[`WB_XLEN-1:0]	csr_rdata,
	input	logic					exc_taken,
	output	rf_write_t				rf_write,
	output	logic					valid_out,
	output	wb_retire_t				retire
);

	//////////////////////////////
	// Register write-back
	always_comb begin
		rf_write.wena	= accept && item.rd_wena && !exc_taken;
		rf_write.addr	= item.rd_addr;
		if (item.wb_src == SEL_CSR)
			rf_write.data = csr_rdata;	// Old CSR value
		else
			rf_write.data = item.rd_data;
	end

	//////////////////////////////
	// Output register
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out	<= 1'b0;
			retire		<= '0;
		end else if (accept) begin
			valid_out	<= 1'b1;
			retire.pc	<= item.pc;
			retire.ir	<= item.ir;
		end else if (valid_out && ready_in) begin
			valid_out	<= 1'b0;	// Drained
			retire		<= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_stage
	import wb_pkg::*;
(
	input	logic							clk,
	input	logic							reset,
	input	logic							valid_in,
	input	logic							ready_in,
	output	logic							ready_out,
	input	mem_wb_t						item,
	input	logic	[`WB_NUM_IRQ_EXT-1:0]	irq_ext,
	input	logic							irq_int_controller,
	input	logic							irq_timer,
	input	logic							irq_software,
	output	logic							valid_out,
	output	wb_retire_t						retire,
	output	rf_write_t						rf_write,
	output	csr_status_t					status
);

	csr_sel_t				csr_sel;
	logic	[`WB_XLEN-1:0]	csr_rdata;
	logic					accept;

	assign ready_out	= ready_in;
	assign accept		= valid_in && ready_out;	// Handshake

	csr_decode csr_decode_inst (
		.item(item),
		.csr_sel(csr_sel)
	);

	csr_file csr_file_inst (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.item(item),
		.csr_sel(csr_sel),
		.irq_ext(irq_ext),
		.irq_int_controller(irq_int_controller),
		.irq_timer(irq_timer),
		.irq_software(irq_software),
		.csr_rdata(csr_rdata),
		.status(status)
	);

	wb_result wb_result_inst (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.ready_in(ready_in),
		.item(item),
		.csr_rdata(csr_rdata),
		.exc_taken(status.exc_taken),
		.rf_write(rf_write),
		.valid_out(valid_out),
		.retire(retire)
	);

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
+incdir+tb
source/wb_pkg.sv
source/csr_decode.sv
source/csr_file.sv
source/wb_result.sv
source/wb_stage.sv
tb/wb_tb.sv

// File: tb/wb_model.svh
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

//////////////////////////////
// Reference CSR state
logic			mdl_mstatus_mie;
logic			mdl_mstatus_mpie;
logic	[1:0]	mdl_fs;
logic	[4:0]	mdl_fflags;
logic	[2:0]	mdl_frm;
logic	[31:0]	mdl_misa, mdl_mie_csr, mdl_mtvec, mdl_mscratch, mdl_mepc, mdl_mcause;

task automatic model_reset();
	mdl_mstatus_mie		= 1'b0;
	mdl_mstatus_mpie	= 1'b0;
	mdl_fs				= 2'b01;	// Initial
	mdl_fflags			= '0;
	mdl_frm				= '0;
	mdl_misa			= `WB_MISA_RESET;
	mdl_mie_csr			= '0;
	mdl_mtvec			= `WB_MTVEC_RESET;
	mdl_mscratch		= '0;
	mdl_mepc			= '0;
	mdl_mcause			= '0;
endtask

function automatic logic [31:0] mstatus_word();
	logic	[31:0]	w;
	w			= '0;
	w[3]		= mdl_mstatus_mie;
	w[7]		= mdl_mstatus_mpie;
	w[12:11]	= 2'b11;	// MPP is always machine
	w[14:13]	= mdl_fs;
	w[31]		= (mdl_fs == 2'b11);
	return w;
endfunction

function automatic logic [31:0] mip_word();
	logic	[31:0]	w;
	w			= '0;
	w[3]		= irq_software;
	w[7]		= irq_timer;
	w[11]		= irq_int_controller;
	w[31:16]	= irq_ext;
	return w;
endfunction

// Top bit flags a mapped address
function automatic logic [32:0] csr_lookup(input logic [11:0] addr);
	case (addr)
		`WB_CSR_FFLAGS:		return {1'b1, 27'h0, mdl_fflags};
		`WB_CSR_FRM:		return {1'b1, 29'h0, mdl_frm};
		`WB_CSR_FCSR:		return {1'b1, 24'h0, mdl_frm, mdl_fflags};
		`WB_CSR_MSTATUS:	return {1'b1, mstatus_word()};
		`WB_CSR_MISA:		return {1'b1, mdl_misa};
		`WB_CSR_MIE:		return {1'b1, mdl_mie_csr};
		`WB_CSR_MTVEC:		return {1'b1, mdl_mtvec};
		`WB_CSR_MSCRATCH:	return {1'b1, mdl_mscratch};
		`WB_CSR_MEPC:		return {1'b1, mdl_mepc};
		`WB_CSR_MCAUSE:		return {1'b1, mdl_mcause};
		`WB_CSR_MIP:		return {1'b1, mip_word()};
		default:			return 33'h0;
	endcase
endfunction

function automatic logic int_pending();
	return mdl_mstatus_mie && ((mip_word() & mdl_mie_csr) != 32'h0);
endfunction

function automatic logic [4:0] irq_priority(input logic [31:0] pend);
	if (pend[11])
		return 5'd11;
	if (pend[3])
		return 5'd3;
	if (pend[7])
		return 5'd7;
	for (int i = 16; i < 32; i++) begin
		if (pend[i])
			return 5'(i);
	end
	return 5'd0;
endfunction

task automatic model_accept(input mem_wb_t it);
	logic	[32:0]	look;
	logic	[31:0]	nv;
	logic	[31:0]	pend;
	logic			take_int;
	logic			old_mie;
	logic			old_mpie;
	look		= csr_lookup(it.csr_addr);
	pend		= mip_word() & mdl_mie_csr;
	take_int	= int_pending();
	old_mie		= mdl_mstatus_mie;
	old_mpie	= mdl_mstatus_mpie;
	case (it.csr_op)
		CSR_RW:		nv = it.csr_wdata;
		CSR_RS:		nv = look[31:0] | it.csr_wdata;
		CSR_RC:		nv = look[31:0] & ~it.csr_wdata;
		default:	nv = look[31:0];
	endcase
	if (it.csr_wena && look[32] && it.csr_addr != `WB_CSR_MIP && !it.exc_pend) begin
		case (it.csr_addr)
			`WB_CSR_FFLAGS:	mdl_fflags = nv[4:0];
			`WB_CSR_FRM:	mdl_frm = nv[2:0];
			`WB_CSR_FCSR: begin
				mdl_frm		= nv[7:5];
				mdl_fflags	= nv[4:0];
			end
			`WB_CSR_MSTATUS: begin
				mdl_mstatus_mie		= nv[3];
				mdl_mstatus_mpie	= nv[7];
				mdl_fs				= nv[14:13];
			end
			`WB_CSR_MISA:		mdl_misa = nv;
			`WB_CSR_MIE:		mdl_mie_csr = nv;
			`WB_CSR_MTVEC:		mdl_mtvec = nv;
			`WB_CSR_MSCRATCH:	mdl_mscratch = nv;
			`WB_CSR_MEPC:		mdl_mepc = nv;
			`WB_CSR_MCAUSE:		mdl_mcause = nv;
			default: ;
		endcase
	end
	mdl_fflags = mdl_fflags | it.fpu_flags;
	if (it.rd_wena && it.rd_addr[5])
		mdl_fs = 2'b11;	// FPU register written
	if (it.exc_pend) begin
		mdl_mepc			= it.pc;
		mdl_mcause			= it.exc_cause;
		mdl_mstatus_mpie	= old_mie;
		mdl_mstatus_mie		= 1'b0;
	end else if (take_int) begin
		mdl_mepc			= it.pc + 32'd4;
		mdl_mcause			= 32'h8000_0000 | irq_priority(pend);
		mdl_mstatus_mpie	= old_mie;
		mdl_mstatus_mie		= 1'b0;
	end else if (it.trap_ret) begin
		mdl_mstatus_mie		= old_mpie;
		mdl_mstatus_mpie	= 1'b1;
	end
endtask

`endif

// File: tb/wb_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_tb
	import wb_pkg::*;
();

	logic							clk;
	logic							reset;
	logic							valid_in;
	logic							ready_in;
	logic							ready_out;
	mem_wb_t						item;
	logic	[`WB_NUM_IRQ_EXT-1:0]	irq_ext;
	logic							irq_int_controller;
	logic							irq_timer;
	logic							irq_software;
	logic							valid_out;
	wb_retire_t						retire;
	rf_write_t						rf_write;
	csr_status_t					status;

	logic							exp_valid;
	wb_retire_t						exp_retire;
	int								passes;
	int								errors;

	`include "wb_model.svh"

	wb_stage dut (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_in(ready_in),
		.ready_out(ready_out),
		.item(item),
		.irq_ext(irq_ext),
		.irq_int_controller(irq_int_controller),
		.irq_timer(irq_timer),
		.irq_software(irq_software),
		.valid_out(valid_out),
		.retire(retire),
		.rf_write(rf_write),
		.status(status)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end else
			passes++;
	endtask

	task automatic report_test(input string name, input int start);
		$display("test %-12s done, %0d errors", name, errors - start);
	endtask

	//////////////////////////////
	// One clock of stimulus and checks
	task automatic drive_cycle(input mem_wb_t it, input logic v, input logic rdy,
			input logic [18:0] irq);
		logic			acc;
		logic			exp_exc;
		logic			exp_int;
		logic			exp_wena;
		logic	[32:0]	look;
		logic	[31:0]	exp_data;
		@(negedge clk);
		item	= it;
		valid_in	= v;
		ready_in	= rdy;
		{irq_ext, irq_int_controller, irq_timer, irq_software} = irq;
		#3;	// Just before the rising edge
		acc			= v && rdy;
		exp_exc		= acc && it.exc_pend;
		exp_int		= acc && !it.exc_pend && int_pending();
		exp_wena	= acc && it.rd_wena && !it.exc_pend;
		look		= csr_lookup(it.csr_addr);
		exp_data	= (look[32] && it.csr_rena) ? look[31:0] : 32'h0;
		if (it.wb_src != SEL_CSR)
			exp_data = it.rd_data;
		check_value("ready_out", rdy, ready_out);
		check_value("valid_out", exp_valid, valid_out);
		check_value("retire", exp_retire, retire);
		check_value("status.exc_taken", exp_exc, status.exc_taken);
		check_value("status.int_taken", exp_int, status.int_taken);
		check_value("status.trap_taken", exp_exc || exp_int, status.trap_taken);
		check_value("status.trap_addr", {mdl_mtvec[31:2], 2'b00}, status.trap_addr);
		check_value("status.trap_raddr", mdl_mepc, status.trap_raddr);
		check_value("status.m_ena", mdl_misa[12], status.m_ena);
		check_value("status.f_ena", mdl_misa[5] && mdl_fs != 2'b00, status.f_ena);
		check_value("status.fpu_rm", mdl_frm, status.fpu_rm);
		check_value("rf_write.wena", exp_wena, rf_write.wena);
		if (exp_wena) begin
			check_value("rf_write.addr", it.rd_addr, rf_write.addr);
			check_value("rf_write.data", exp_data, rf_write.data);
		end
		if (acc) begin
			model_accept(it);
			exp_valid	= 1'b1;
			exp_retire	= {it.pc, it.ir};
		end else if (exp_valid && rdy) begin
			exp_valid	= 1'b0;	// Drained
			exp_retire	= '0;
		end
	endtask

	task automatic csr_access(input logic [11:0] addr, input csr_op_e op, input logic wena,
			input logic [31:0] data);
		mem_wb_t	it;
		it				= '0;
		it.pc			= 32'h0000_1000;
		it.rd_wena		= 1'b1;
		it.rd_addr		= 6'd5;	// Integer register
		it.csr_addr		= addr;
		it.csr_rena		= 1'b1;
		it.csr_wena		= wena;
		it.csr_wdata	= data;
		it.wb_src		= SEL_CSR;
		it.csr_op		= op;
		drive_cycle(it, 1'b1, 1'b1, '0);
	endtask

	function automatic mem_wb_t random_item(input int exc_pct, input int ret_pct);
		mem_wb_t		it;
		logic	[11:0]	addrs [11];
		addrs = '{`WB_CSR_FFLAGS, `WB_CSR_FRM, `WB_CSR_FCSR, `WB_CSR_MSTATUS,
			`WB_CSR_MISA, `WB_CSR_MIE, `WB_CSR_MTVEC, `WB_CSR_MSCRATCH,
			`WB_CSR_MEPC, `WB_CSR_MCAUSE, `WB_CSR_MIP};
		it				= '0;
		it.pc			= $urandom & 32'hFFFF_FFFC;
		it.ir			= $urandom;
		it.rd_wena		= 1'($urandom);
		it.rd_addr		= 6'($urandom);
		it.rd_data		= $urandom;
		it.csr_addr		= ($urandom % 8 == 0) ? 12'($urandom) : addrs[$urandom % 11];
		it.csr_rena		= ($urandom % 4) != 0;
		it.csr_wena		= 1'($urandom);
		it.csr_wdata	= $urandom;
		it.wb_src		= wb_src_e'($urandom % 4);
		it.csr_op		= csr_op_e'($urandom % 4);
		it.fpu_flags	= ($urandom % 4 == 0) ? 5'($urandom) : 5'h0;
		it.trap_ret		= ($urandom % 100) < ret_pct;
		it.exc_pend		= ($urandom % 100) < exc_pct;
		it.exc_cause	= $urandom % 16;
		return it;
	endfunction

	// Sparse ext lines so the priority order gets exercised
	function automatic logic [18:0] random_irq(input int pct);
		if (($urandom % 100) >= pct)
			return '0;
		return {16'($urandom & $urandom & $urandom), 3'($urandom)};
	endfunction

	task automatic run_random(input string name, input int n, input int exc_pct,
			input int ret_pct, input int irq_pct);
		int	start;
		start = errors;
		for (int i = 0; i < n; i++)
			drive_cycle(random_item(exc_pct, ret_pct), ($urandom % 8) != 0,
				($urandom % 4) != 0, random_irq(irq_pct));
		report_test(name, start);
	endtask

	initial begin
		int			start;
		int			waited;
		mem_wb_t	it_a;
		mem_wb_t	it_b;
		void'($urandom(32190));
		passes				= 0;
		errors				= 0;
		reset				= 1'b1;
		valid_in			= 1'b0;
		ready_in			= 1'b0;
		item				= '0;
		irq_ext				= '0;
		irq_int_controller	= 1'b0;
		irq_timer			= 1'b0;
		irq_software		= 1'b0;
		exp_valid			= 1'b0;
		exp_retire			= '0;
		model_reset();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		//////////////////////////////
		// Reset state
		start = errors;
		#3;
		check_value("valid_out", 0, valid_out);
		check_value("rf_write.wena", 0, rf_write.wena);
		check_value("status.trap_taken", 0, status.trap_taken);
		check_value("status.int_taken", 0, status.int_taken);
		check_value("status.exc_taken", 0, status.exc_taken);
		check_value("status.m_ena", 1, status.m_ena);
		check_value("status.f_ena", 1, status.f_ena);
		csr_access(`WB_CSR_MTVEC, CSR_NONE, 1'b0, 32'h0);
		check_value("rf_write.data", `WB_MTVEC_RESET, rf_write.data);
		csr_access(`WB_CSR_MISA, CSR_NONE, 1'b0, 32'h0);
		check_value("rf_write.data", `WB_MISA_RESET, rf_write.data);
		report_test("reset", start);

		run_random("csr_ops", 400, 0, 0, 0);
		run_random("exceptions", 300, 15, 15, 0);

		csr_access(`WB_CSR_MIE, CSR_RW, 1'b1, 32'hFFFF_FFFF);
		csr_access(`WB_CSR_MSTATUS, CSR_RS, 1'b1, 32'h0000_0008);
		run_random("interrupts", 400, 5, 25, 40);

		//////////////////////////////
		// FPU state
		start				= errors;
		it_a				= '0;
		it_a.rd_wena		= 1'b1;
		it_a.rd_addr		= 6'h21;	// FPU register
		it_a.fpu_flags		= 5'h05;
		drive_cycle(it_a, 1'b1, 1'b1, '0);
		it_a.fpu_flags		= 5'h12;
		drive_cycle(it_a, 1'b1, 1'b1, '0);
		csr_access(`WB_CSR_MSTATUS, CSR_NONE, 1'b0, 32'h0);
		check_value("mstatus[31]", 1, rf_write.data[31]);
		check_value("mstatus.fs", 2'b11, rf_write.data[14:13]);
		csr_access(`WB_CSR_FFLAGS, CSR_NONE, 1'b0, 32'h0);
		check_value("fflags", 5'h17, rf_write.data[4:0] & 5'h17);
		csr_access(`WB_CSR_MISA, CSR_RC, 1'b1, 32'h0000_0020);
		csr_access(`WB_CSR_MISA, CSR_NONE, 1'b0, 32'h0);
		check_value("status.f_ena", 0, status.f_ena);
		report_test("fpu_state", start);

		//////////////////////////////
		// Back-pressure and retire timing
		start	= errors;
		it_a	= random_item(0, 0);
		it_b	= random_item(0, 0);
		drive_cycle(it_a, 1'b1, 1'b1, '0);
		for (int i = 0; i < 5; i++)
			drive_cycle(random_item(0, 0), 1'b1, 1'b0, random_irq(50));
		check_value("retire.pc", it_a.pc, retire.pc);
		check_value("retire.ir", it_a.ir, retire.ir);
		drive_cycle('0, 1'b0, 1'b1, '0);
		drive_cycle(it_b, 1'b1, 1'b1, '0);
		waited = 0;
		while (!valid_out && waited < 20) begin
			drive_cycle('0, 1'b0, 1'b0, '0);
			waited++;
		end
		if (!valid_out) begin
			errors++;
			$display("Timeout: valid_out did not rise within 20 cycles of an accept");
		end else begin
			check_value("valid_out latency", 1, waited);
			check_value("retire.pc", it_b.pc, retire.pc);
			check_value("retire.ir", it_b.ir, retire.ir);
		end
		report_test("backpressure", start);

		run_random("mixed", 200, 5, 10, 20);

		$display("checks passed: %0d, failed: %0d", passes, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
